// ==== all.f ====
+incdir+testbench
rtl/agc_pkg.sv
rtl/agc_regs_pkg.sv
rtl/agc_gain_stage.sv
rtl/agc_power_meter.sv
rtl/agc_balance_counter.sv
rtl/agc_servo.sv
rtl/agc_apb_regs.sv
rtl/agc_top.sv
testbench/tb_agc_top.sv

// ==== Bender.yml ====
package:
  name: agc

sources:
  - rtl/agc_pkg.sv
  - rtl/agc_regs_pkg.sv
  - rtl/agc_gain_stage.sv
  - rtl/agc_power_meter.sv
  - rtl/agc_balance_counter.sv
  - rtl/agc_servo.sv
  - rtl/agc_apb_regs.sv
  - rtl/agc_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_agc_top.sv

// ==== testbench/tb_agc_tasks.svh ====
`ifndef TB_AGC_TASKS_SVH
`define TB_AGC_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Typed compare tasks

task automatic check_word(input logic [APB_DW-1:0] got, input logic [APB_DW-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("[FAIL] t=%0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        value_errs++;
    end
endtask

task automatic check_lanes(input out_lanes_t got, input out_lanes_t exp, input string what);
    if (got !== exp) begin
        $display("[FAIL] t=%0d ns: %s is 0x%06h, expected 0x%06h", $time, what, got, exp);
        value_errs++;
    end
endtask

task automatic check_gain(input gain_t got, input gain_t exp, input string what);
    if (got !== exp) begin
        $display("[FAIL] t=%0d ns: %s is scale %0d offset %0d, expected scale %0d offset %0d",
                 $time, what, got.scale, got.offset, exp.scale, exp.offset);
        value_errs++;
    end
endtask

// Sampled in the access phase
task automatic check_apb_rsp(input logic [APB_AW-1:0] addr, input logic exp_err);
    if (!apb_rsp_o.pready) begin
        $display("t=%0d ns: pready stayed low in the access phase to 0x%02h", $time, addr);
        proto_errs++;
    end
    if (apb_rsp_o.pslverr && !exp_err) begin
        $display("t=%0d ns: unexpected slave error on access to 0x%02h", $time, addr);
        proto_errs++;
    end else if (!apb_rsp_o.pslverr && exp_err) begin
        $display("t=%0d ns: no slave error on bad access to 0x%02h", $time, addr);
        proto_errs++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// APB driver entered and left 1 ns after a rising edge

task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                         input logic exp_err);
    apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge aclk);
    #1;
    apb_req_i.penable = 1'b1;
    @(negedge aclk);
    check_apb_rsp(addr, exp_err);
    @(posedge aclk);
    #1;
    apb_req_i = '0;
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                        input logic exp_err);
    apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge aclk);
    #1;
    apb_req_i.penable = 1'b1;
    @(negedge aclk);
    check_apb_rsp(addr, exp_err);
    data = apb_rsp_o.prdata;
    @(posedge aclk);
    #1;
    apb_req_i = '0;
endtask

task automatic write_gain(input gain_t g);
    apb_write(REG_SCALE, APB_DW'(g.scale), 1'b0);
    apb_write(REG_OFFSET, {{(APB_DW - OFFSET_W){g.offset[OFFSET_W-1]}}, g.offset}, 1'b0);
    model_gain = g;
endtask

task automatic read_gain(output gain_t g);
    logic [APB_DW-1:0] d;
    apb_read(REG_SCALE, d, 1'b0);
    g.scale = d[SCALE_W-1:0];
    apb_read(REG_OFFSET, d, 1'b0);
    g.offset = d[OFFSET_W-1:0];
endtask

// Window end seen on the power meter's done pulse
task automatic wait_window_done(input int max_cycles);
    logic seen;
    seen = 1'b0;
    for (int c = 0; c < max_cycles && !seen; c++) begin
        @(negedge aclk);
        seen = i_agc_top.power.done;
        @(posedge aclk);
        #1;
    end
    if (!seen) begin
        $display("t=%0d ns: window never ended within %0d cycles", $time, max_cycles);
        proto_errs++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Sample driver that checks each beat two cycles after its input

task automatic stream_beats(input int n_beats, input logic use_rand, input in_lanes_t pattern,
                            output int sum_sq, output int pos_cnt, output int neg_cnt);
    out_lanes_t  exp_q[$];
    in_lanes_t   beat;
    out_lanes_t  exp_beat;
    logic [31:0] rnd;
    int          v;
    sum_sq  = 0;
    pos_cnt = 0;
    neg_cnt = 0;
    for (int i = 0; i < n_beats + 2; i++) begin
        if (i < n_beats) begin
            beat       = pattern;
            beat.valid = 1'b1;
            for (int l = 0; l < N_LANES; l++) begin
                if (use_rand) begin
                    rnd          = $random(seed);
                    beat.lane[l] = rnd[IN_W-1:0];
                end
                exp_beat.lane[l] = model_sample(beat.lane[l], model_gain);
                v                = int'(exp_beat.lane[l]);
                sum_sq          += v * v;
                if (v > 0) pos_cnt++;
                if (v < 0) neg_cnt++;
            end
            exp_beat.valid = 1'b1;
            exp_q.push_back(exp_beat);
            samples_i = beat;
        end else begin
            samples_i.valid = 1'b0;
        end
        @(negedge aclk);
        if (i >= 2) begin
            exp_beat = exp_q.pop_front();
            if (!samples_o.valid) begin
                $display("t=%0d ns: output beat %0d missing two cycles after its input",
                         $time, i - 2);
                proto_errs++;
            end else begin
                check_lanes(samples_o, exp_beat, "gain stage output");
            end
        end
        @(posedge aclk);
        #1;
    end
endtask

`endif

// ==== testbench/tb_agc_top.sv ====
module tb_agc_top;
    timeunit 1ns;
    timeprecision 1ps;

    import agc_pkg::*;
    import agc_regs_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int WIN_LOG2      = 4;
    localparam int WIN_BEATS     = 2 ** WIN_LOG2;
    localparam int TARGET_RMS_SQ = 16;     // DUT loop defaults
    localparam int RMS_SQ_ERR    = 0;
    localparam int OFFSET_ERR    = 5;
    localparam int DONE_WAIT     = 8;
    localparam int MAX_WINDOWS   = 40;

    // Watchdog budget, in cycles per part of the run
    localparam int REG_CYCLES    = 120;
    localparam int STREAM_CYCLES = 3 * WIN_BEATS + 60;
    localparam int WINDOW_CYCLES = WIN_BEATS + DONE_WAIT + 20;
    localparam int LOOP_CYCLES   = (MAX_WINDOWS + 8) * WINDOW_CYCLES;
    localparam int WATCHDOG_NS   = 2 * CLK_PERIOD *
                                   (RESET_CYCLES + REG_CYCLES + STREAM_CYCLES + LOOP_CYCLES);

    logic       aclk = 1'b0;
    logic       wb_rst_i;
    in_lanes_t  samples_i;
    out_lanes_t samples_o;
    apb_req_t   apb_req_i;
    apb_rsp_t   apb_rsp_o;

    integer     seed = 32'h9d08;
    int         value_errs = 0;
    int         proto_errs = 0;
    gain_t      model_gain;           // Gain the DUT should hold now
    int         sdelta;
    int         odelta;

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    agc_top #(.WINDOW_LOG2(WIN_LOG2)) i_agc_top (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .samples_i (samples_i),
        .samples_o (samples_o),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Scale, offset in 1/16 steps, floor, clip to the 5-bit range
    function automatic out_sample_t model_sample(input in_sample_t x, input gain_t g);
        longint acc;
        acc = longint'(x) * longint'(g.scale) +
              longint'(g.offset) * (longint'(1) << (SCALE_SHIFT - OFFSET_FRAC));
        acc = acc >>> SCALE_SHIFT;
        if (acc > OUT_MAX) begin
            acc = OUT_MAX;
        end else if (acc < OUT_MIN) begin
            acc = OUT_MIN;
        end
        return out_sample_t'(acc);
    endfunction

    function automatic gain_t model_servo(input gain_t g, input int ms, input int pos,
                                          input int neg, input int sd, input int od);
        gain_t next;
        int    s;
        next = g;
        s    = int'(g.scale);
        if (ms > TARGET_RMS_SQ + RMS_SQ_ERR && s > SCALE_MIN) begin
            next.scale = SCALE_W'(s - sd);
        end else if (ms < TARGET_RMS_SQ - RMS_SQ_ERR && s < SCALE_MAX) begin
            next.scale = SCALE_W'(s + sd);
        end
        if (pos > neg + OFFSET_ERR) begin
            next.offset = g.offset - OFFSET_W'(od);
        end else if (neg > pos + OFFSET_ERR) begin
            next.offset = g.offset + OFFSET_W'(od);
        end
        return next;
    endfunction

    `include "tb_agc_tasks.svh"

    // One window with the loop running, then the new gain is checked
    task automatic loop_window(input in_lanes_t pat, output logic settled);
        int                sq;
        int                p;
        int                n;
        int                ms;
        gain_t             next_gain;
        gain_t             dut_gain;
        logic [APB_DW-1:0] d;
        stream_beats(WIN_BEATS, 1'b0, pat, sq, p, n);
        wait_window_done(DONE_WAIT);
        ms        = sq >> (WIN_LOG2 + 2);
        next_gain = model_servo(model_gain, ms, p, n, sdelta, odelta);
        apb_read(REG_RMS_SQ, d, 1'b0);
        check_word(d, APB_DW'(ms), "window mean square");
        read_gain(dut_gain);
        check_gain(dut_gain, next_gain, "gain after window");
        settled    = (next_gain.scale == model_gain.scale) || (next_gain.scale <= SCALE_MIN);
        model_gain = next_gain;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_values();
        logic [APB_DW-1:0] d;
        $display("Test 1, register values after reset");
        model_gain = '{scale: SCALE_W'(START_SCALE), offset: '0};
        sdelta     = 30;
        odelta     = 25;
        apb_read(REG_CTRL, d, 1'b0);
        check_word(d, 32'd1, "loop enable");
        apb_read(REG_SCALE_DELTA, d, 1'b0);
        check_word(d, 32'd30, "scale delta");
        apb_read(REG_OFFSET_DELTA, d, 1'b0);
        check_word(d, 32'd25, "offset delta");
        apb_read(REG_SCALE, d, 1'b0);
        check_word(d, 32'd1500, "scale");
        apb_read(REG_OFFSET, d, 1'b0);
        check_word(d, 32'd0, "offset");
        apb_read(REG_RMS_SQ, d, 1'b0);
        check_word(d, 32'd0, "mean square");
        apb_read(REG_BALANCE, d, 1'b0);
        check_word(d, 32'd0, "balance");
    endtask

    task automatic test_register_access();
        logic [APB_DW-1:0] d;
        $display("Test 2, register writes and slave errors");
        apb_write(REG_SCALE_DELTA, 32'd77, 1'b0);
        apb_write(REG_OFFSET_DELTA, 32'd13, 1'b0);
        apb_write(REG_CTRL, 32'd0, 1'b0);
        apb_read(REG_SCALE_DELTA, d, 1'b0);
        check_word(d, 32'd77, "scale delta readback");
        apb_read(REG_OFFSET_DELTA, d, 1'b0);
        check_word(d, 32'd13, "offset delta readback");
        apb_read(REG_CTRL, d, 1'b0);
        check_word(d, 32'd0, "loop enable readback");
        apb_read(8'h1C, d, 1'b1);                      // Unmapped
        apb_write(REG_RMS_SQ, 32'h1F, 1'b1);           // Read only
        apb_read(REG_RMS_SQ, d, 1'b0);
        check_word(d, 32'd0, "mean square after rejected write");
        apb_write(REG_SCALE_DELTA, 32'd30, 1'b0);
        apb_write(REG_OFFSET_DELTA, 32'd25, 1'b0);
    endtask

    task automatic test_manual_gain();
        gain_t             g;
        gain_t             dut_gain;
        logic [APB_DW-1:0] d;
        int                sq;
        int                p;
        int                n;
        $display("Test 3, manual gain with random samples");
        apb_write(REG_CTRL, 32'd0, 1'b0);
        g = '{scale: SCALE_W'(2000), offset: OFFSET_W'(-40)};
        write_gain(g);
        read_gain(dut_gain);
        check_gain(dut_gain, g, "manual gain");
        apb_read(REG_OFFSET, d, 1'b0);
        check_word(d, 32'hFFFF_FFD8, "offset sign extension");
        stream_beats(2 * WIN_BEATS, 1'b1, '0, sq, p, n);  // Keeps windows aligned
    endtask

    task automatic test_window_measure();
        in_lanes_t         pat;
        logic [APB_DW-1:0] d;
        int                sq;
        int                p;
        int                n;
        $display("Test 4, window measurements on constant input");
        pat.valid   = 1'b1;
        pat.lane[0] = 12'sd300;
        pat.lane[1] = -12'sd500;
        pat.lane[2] = 12'sd40;
        pat.lane[3] = '0;
        stream_beats(WIN_BEATS, 1'b0, pat, sq, p, n);
        wait_window_done(DONE_WAIT);
        apb_read(REG_RMS_SQ, d, 1'b0);
        check_word(d, APB_DW'(sq >> (WIN_LOG2 + 2)), "window mean square");
        apb_read(REG_BALANCE, d, 1'b0);
        check_word(d, {n[15:0], p[15:0]}, "window balance");
    endtask

    task automatic test_power_loop();
        in_lanes_t pat;
        gain_t     g;
        logic      settled;
        int        w;
        $display("Test 5, scale loop on alternating input");
        pat.valid = 1'b1;
        for (int l = 0; l < N_LANES; l++) begin
            pat.lane[l] = (l % 2 == 0) ? 12'sd1500 : -12'sd1500;
        end
        apb_write(REG_SCALE_DELTA, 32'd100, 1'b0);
        sdelta = 100;
        g      = '{scale: SCALE_W'(START_SCALE), offset: '0};
        write_gain(g);
        apb_write(REG_CTRL, 32'd1, 1'b0);
        settled = 1'b0;
        w       = 0;
        while (!settled && w < MAX_WINDOWS) begin
            loop_window(pat, settled);
            w++;
        end
        $display("  loop stopped after %0d windows at scale %0d", w, model_gain.scale);
    endtask

    task automatic test_offset_loop();
        in_lanes_t pat;
        gain_t     g;
        gain_t     frozen;
        gain_t     dut_gain;
        logic      settled;
        int        sq;
        int        p;
        int        n;
        $display("Test 6, offset loop on DC input, then loop frozen");
        pat.valid = 1'b1;
        for (int l = 0; l < N_LANES; l++) begin
            pat.lane[l] = 12'sd1000;
        end
        apb_write(REG_SCALE_DELTA, 32'd30, 1'b0);
        sdelta = 30;
        g      = '{scale: SCALE_W'(START_SCALE), offset: '0};
        write_gain(g);
        repeat (4) loop_window(pat, settled);        // Loop still enabled
        apb_write(REG_CTRL, 32'd0, 1'b0);
        frozen = model_gain;
        repeat (2) begin
            stream_beats(WIN_BEATS, 1'b0, pat, sq, p, n);
            wait_window_done(DONE_WAIT);
        end
        read_gain(dut_gain);
        check_gain(dut_gain, frozen, "gain with loop disabled");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog

    initial begin
        wb_rst_i  = 1'b1;
        samples_i = '0;
        apb_req_i = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        wb_rst_i = 1'b0;

        test_reset_values();
        test_register_access();
        test_manual_gain();
        test_window_measure();
        test_power_loop();
        test_offset_loop();

        $display("Errors: %0d value mismatches, %0d protocol or timing failures",
                 value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== rtl/agc_top.sv ====
module agc_top #(
    parameter int WINDOW_LOG2   = 6,
    parameter int TARGET_RMS_SQ = 16,
    parameter int RMS_SQ_ERR    = 0,
    parameter int OFFSET_ERR    = 5
) (
    input  logic                   aclk,
    input  logic                   wb_rst_i,
    input  agc_pkg::in_lanes_t     samples_i,
    output agc_pkg::out_lanes_t    samples_o,
    input  agc_regs_pkg::apb_req_t apb_req_i,
    output agc_regs_pkg::apb_rsp_t apb_rsp_o
);
    import agc_pkg::*;
    import agc_regs_pkg::*;

    gain_t         gain;
    power_meas_t   power;
    balance_meas_t balance;
    servo_cfg_t    cfg;
    gain_load_t    gain_load;

    if (WINDOW_LOG2 < 1 || WINDOW_LOG2 > 13) begin : g_bad_window
        $error("WINDOW_LOG2 must lie in 1..13");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data path and measurements
    agc_gain_stage i_gain_stage (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .samples_i (samples_i),
        .gain_i    (gain),
        .samples_o (samples_o)
    );

    agc_power_meter #(.WINDOW_LOG2(WINDOW_LOG2)) i_power_meter (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .samples_i (samples_o),
        .power_o   (power)
    );

    agc_balance_counter #(.WINDOW_LOG2(WINDOW_LOG2)) i_balance_counter (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .samples_i (samples_o),
        .balance_o (balance)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control loop and register access
    agc_servo #(
        .TARGET_RMS_SQ (TARGET_RMS_SQ),
        .RMS_SQ_ERR    (RMS_SQ_ERR),
        .OFFSET_ERR    (OFFSET_ERR)
    ) i_servo (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .power_i   (power),
        .balance_i (balance),
        .cfg_i     (cfg),
        .load_i    (gain_load),
        .gain_o    (gain)
    );

    agc_apb_regs i_apb_regs (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .gain_i    (gain),
        .power_i   (power),
        .balance_i (balance),
        .cfg_o     (cfg),
        .load_o    (gain_load)
    );

endmodule

// ==== rtl/agc_apb_regs.sv ====
module agc_apb_regs (
    input  logic                     aclk,
    input  logic                     wb_rst_i,
    input  agc_regs_pkg::apb_req_t   apb_req_i,
    output agc_regs_pkg::apb_rsp_t   apb_rsp_o,
    input  agc_pkg::gain_t           gain_i,
    input  agc_pkg::power_meas_t     power_i,
    input  agc_pkg::balance_meas_t   balance_i,
    output agc_regs_pkg::servo_cfg_t cfg_o,
    output agc_regs_pkg::gain_load_t load_o
);
    import agc_pkg::*;
    import agc_regs_pkg::*;

    logic                access;
    logic                wr_en;
    logic                addr_hit;
    logic                read_only;
    logic [APB_DW-1:0]   rd_data;
    logic [RMS_SQ_W-1:0] rms_sq_q;
    logic [CNT_W-1:0]    pos_q;
    logic [CNT_W-1:0]    neg_q;

    assign access = apb_req_i.psel && apb_req_i.penable;
    assign wr_en  = access && apb_req_i.pwrite && addr_hit && !read_only;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode and read mux
    always_comb begin
        addr_hit  = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (apb_req_i.paddr)
            REG_CTRL:         rd_data = APB_DW'(cfg_o.enable);
            REG_SCALE_DELTA:  rd_data = APB_DW'(cfg_o.scale_delta);
            REG_OFFSET_DELTA: rd_data = APB_DW'(cfg_o.offset_delta);
            REG_SCALE:        rd_data = APB_DW'(gain_i.scale);     // Live gain
            REG_OFFSET:       rd_data = APB_DW'(gain_i.offset);    // Sign-extended
            REG_RMS_SQ: begin
                rd_data   = APB_DW'(rms_sq_q);
                read_only = 1'b1;
            end
            REG_BALANCE: begin
                rd_data   = {neg_q, pos_q};
                read_only = 1'b1;
            end
            default:          addr_hit = 1'b0;
        endcase
    end

    // Zero wait states
    assign apb_rsp_o = '{prdata:  rd_data,
                         pready:  access,
                         pslverr: access && (!addr_hit || (apb_req_i.pwrite && read_only))};

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            cfg_o       <= CFG_RESET;
            load_o.load <= 1'b0;
            rms_sq_q    <= '0;
            pos_q       <= '0;
            neg_q       <= '0;
        end else begin
            load_o.load <= 1'b0;
            if (wr_en) begin
                case (apb_req_i.paddr)
                    REG_CTRL:              cfg_o.enable       <= apb_req_i.pwdata[0];
                    REG_SCALE_DELTA:       cfg_o.scale_delta  <= apb_req_i.pwdata[SCALE_W-1:0];
                    REG_OFFSET_DELTA:      cfg_o.offset_delta <= apb_req_i.pwdata[OFFSET_W-1:0];
                    REG_SCALE, REG_OFFSET: load_o.load        <= 1'b1;
                    default: ;
                endcase
            end
            if (power_i.done) rms_sq_q <= power_i.rms_sq;
            if (balance_i.done) begin
                pos_q <= balance_i.pos_cnt;
                neg_q <= balance_i.neg_cnt;
            end
        end
        // Load payload, qualified by load_o.load
        load_o.sel_offset  <= (apb_req_i.paddr == REG_OFFSET);
        load_o.gain.scale  <= apb_req_i.pwdata[SCALE_W-1:0];
        load_o.gain.offset <= apb_req_i.pwdata[OFFSET_W-1:0];
    end

    // Access phase only ever follows a setup phase
    a_apb_phase: assert property (@(posedge aclk) disable iff (wb_rst_i)
        apb_req_i.penable |-> apb_req_i.psel && $past(apb_req_i.psel && !apb_req_i.penable));

endmodule

// ==== rtl/agc_servo.sv ====
module agc_servo #(
    parameter int TARGET_RMS_SQ = 16,
    parameter int RMS_SQ_ERR    = 0,
    parameter int OFFSET_ERR    = 5
) (
    input  logic                     aclk,
    input  logic                     wb_rst_i,
    input  agc_pkg::power_meas_t     power_i,
    input  agc_pkg::balance_meas_t   balance_i,
    input  agc_regs_pkg::servo_cfg_t cfg_i,
    input  agc_regs_pkg::gain_load_t load_i,
    output agc_pkg::gain_t           gain_o
);
    import agc_pkg::*;

    logic                       step;
    int                         rms_sq;
    int                         pos_cnt;
    int                         neg_cnt;
    logic [SCALE_W-1:0]         scale_d;
    logic signed [OFFSET_W-1:0] offset_d;
    logic                       scale_ok;   // Within one step of the cutoffs

    assign step = power_i.done && cfg_i.enable;   // Balance ends on the same beat

    ////////////////////////////////////////////////////////////////////////////
    // Loop step
    always_comb begin
        rms_sq   = int'(power_i.rms_sq);
        pos_cnt  = int'(balance_i.pos_cnt);
        neg_cnt  = int'(balance_i.neg_cnt);
        scale_d  = gain_o.scale;
        offset_d = gain_o.offset;

        // Scale tracks the power target
        if (rms_sq > TARGET_RMS_SQ + RMS_SQ_ERR) begin
            if (gain_o.scale > SCALE_MIN) scale_d = gain_o.scale - cfg_i.scale_delta;
        end else if (rms_sq < TARGET_RMS_SQ - RMS_SQ_ERR) begin
            if (gain_o.scale < SCALE_MAX) scale_d = gain_o.scale + cfg_i.scale_delta;
        end

        // Offset pulls the sign balance back to even
        if (pos_cnt > neg_cnt + OFFSET_ERR) begin
            offset_d = gain_o.offset - cfg_i.offset_delta;
        end else if (neg_cnt > pos_cnt + OFFSET_ERR) begin
            offset_d = gain_o.offset + cfg_i.offset_delta;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Gain register
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            gain_o.scale  <= SCALE_W'(START_SCALE);
            gain_o.offset <= OFFSET_W'(START_OFFSET);
        end else if (load_i.load) begin                // Manual load beats the loop
            if (load_i.sel_offset) begin
                gain_o.offset <= load_i.gain.offset;
            end else begin
                gain_o.scale <= load_i.gain.scale;
            end
        end else if (step) begin
            gain_o <= '{scale: scale_d, offset: offset_d};
        end
    end

    assign scale_ok = (gain_o.scale + cfg_i.scale_delta >= SCALE_MIN) &&
                      (gain_o.scale <= SCALE_MAX + cfg_i.scale_delta);

    // Loop alone never leaves the cutoffs by more than one step
    a_scale_range: assert property (@(posedge aclk) disable iff (wb_rst_i)
        step && !load_i.load && scale_ok |=>
            (gain_o.scale + $past(cfg_i.scale_delta) >= SCALE_MIN) &&
            (gain_o.scale <= SCALE_MAX + $past(cfg_i.scale_delta)));

endmodule

// ==== rtl/agc_balance_counter.sv ====
module agc_balance_counter #(
    parameter int WINDOW_LOG2 = 6
) (
    input  logic                   aclk,
    input  logic                   wb_rst_i,
    input  agc_pkg::out_lanes_t    samples_i,
    output agc_pkg::balance_meas_t balance_o
);
    import agc_pkg::*;

    localparam int LANE_LOG2 = $clog2(N_LANES);

    logic [WINDOW_LOG2-1:0] beat_cnt_q;
    logic [CNT_W-1:0]       pos_q;
    logic [CNT_W-1:0]       neg_q;
    logic [LANE_LOG2:0]     pos_beat;
    logic [LANE_LOG2:0]     neg_beat;

    // Zero lanes count in neither
    always_comb begin
        pos_beat = '0;
        neg_beat = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (samples_i.lane[i] > 0) pos_beat++;
            if (samples_i.lane[i] < 0) neg_beat++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window counts
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            beat_cnt_q <= '0;
            pos_q      <= '0;
            neg_q      <= '0;
            balance_o  <= '0;
        end else begin
            balance_o.done <= 1'b0;
            if (samples_i.valid) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (&beat_cnt_q) begin
                    pos_q     <= '0;
                    neg_q     <= '0;
                    balance_o <= '{done:    1'b1,
                                   pos_cnt: pos_q + pos_beat,
                                   neg_cnt: neg_q + neg_beat};
                end else begin
                    pos_q <= pos_q + pos_beat;
                    neg_q <= neg_q + neg_beat;
                end
            end
        end
    end

endmodule

// ==== rtl/agc_power_meter.sv ====
module agc_power_meter #(
    parameter int WINDOW_LOG2 = 6
) (
    input  logic                 aclk,
    input  logic                 wb_rst_i,
    input  agc_pkg::out_lanes_t  samples_i,
    output agc_pkg::power_meas_t power_o
);
    import agc_pkg::*;

    localparam int LANE_LOG2  = $clog2(N_LANES);
    localparam int SQ_W       = 2 * OUT_W - 1;
    localparam int BEAT_W     = SQ_W + LANE_LOG2;       // Sum of one beat
    localparam int ACC_W      = BEAT_W + WINDOW_LOG2;
    localparam int MEAN_SHIFT = WINDOW_LOG2 + LANE_LOG2; // Samples per window

    logic [WINDOW_LOG2-1:0] beat_cnt_q;
    logic [ACC_W-1:0]       acc_q;
    logic [BEAT_W-1:0]      beat_sq;
    logic [ACC_W-1:0]       acc_next;

    always_comb begin
        beat_sq = '0;
        for (int i = 0; i < N_LANES; i++) begin
            beat_sq += BEAT_W'(samples_i.lane[i] * samples_i.lane[i]);
        end
        acc_next = acc_q + ACC_W'(beat_sq);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window accumulation
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            beat_cnt_q <= '0;
            acc_q      <= '0;
            power_o    <= '0;
        end else begin
            power_o.done <= 1'b0;
            if (samples_i.valid) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (&beat_cnt_q) begin
                    // Last beat closes the window
                    acc_q   <= '0;
                    power_o <= '{done: 1'b1, rms_sq: RMS_SQ_W'(acc_next >> MEAN_SHIFT)};
                end else begin
                    acc_q <= acc_next;
                end
            end
        end
    end

    // Windows hold at least two beats
    a_done_pulse: assert property (@(posedge aclk) disable iff (wb_rst_i)
        power_o.done |=> !power_o.done);

endmodule

// ==== rtl/agc_gain_stage.sv ====
module agc_gain_stage (
    input  logic                aclk,
    input  logic                wb_rst_i,
    input  agc_pkg::in_lanes_t  samples_i,
    input  agc_pkg::gain_t      gain_i,
    output agc_pkg::out_lanes_t samples_o
);
    import agc_pkg::*;

    localparam int PROD_W    = IN_W + SCALE_W + 1;        // Scale gets a sign bit
    localparam int SUM_W     = PROD_W + 2;
    localparam int OFF_ALIGN = SCALE_SHIFT - OFFSET_FRAC; // Offset LSB in product units

    logic                       valid_q;
    logic signed [PROD_W-1:0]   prod_q [N_LANES];
    logic signed [OFFSET_W-1:0] offset_q;
    logic signed [SUM_W-1:0]    shr_c  [N_LANES];
    logic signed [OUT_W-1:0]    sat_c  [N_LANES];

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, multiply
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= samples_i.valid;
        end
        if (samples_i.valid) begin
            for (int i = 0; i < N_LANES; i++) begin
                prod_q[i] <= samples_i.lane[i] * $signed({1'b0, gain_i.scale});
            end
            offset_q <= gain_i.offset;                    // Same gain as the product
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, offset, floor shift and saturate
    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            shr_c[i] = (SUM_W'(prod_q[i]) + (SUM_W'(offset_q) <<< OFF_ALIGN)) >>> SCALE_SHIFT;
            if (shr_c[i] > OUT_MAX) begin
                sat_c[i] = OUT_W'(OUT_MAX);
            end else if (shr_c[i] < OUT_MIN) begin
                sat_c[i] = OUT_W'(OUT_MIN);
            end else begin
                sat_c[i] = shr_c[i][OUT_W-1:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            samples_o.valid <= 1'b0;
        end else begin
            samples_o.valid <= valid_q;
        end
        if (valid_q) begin
            for (int i = 0; i < N_LANES; i++) begin
                samples_o.lane[i] <= sat_c[i];
            end
        end
    end

    // Fixed two-cycle latency
    a_latency: assert property (@(posedge aclk) disable iff (wb_rst_i)
        samples_o.valid == $past(samples_i.valid, 2));

endmodule

// ==== rtl/agc_regs_pkg.sv ====
package agc_regs_pkg;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // Register map
    localparam logic [APB_AW-1:0] REG_CTRL         = 8'h00;   // Bit 0 loop enable
    localparam logic [APB_AW-1:0] REG_SCALE_DELTA  = 8'h04;
    localparam logic [APB_AW-1:0] REG_OFFSET_DELTA = 8'h08;
    localparam logic [APB_AW-1:0] REG_SCALE        = 8'h0C;
    localparam logic [APB_AW-1:0] REG_OFFSET       = 8'h10;
    localparam logic [APB_AW-1:0] REG_RMS_SQ       = 8'h14;   // Read only
    localparam logic [APB_AW-1:0] REG_BALANCE      = 8'h18;   // Read only, {neg, pos}

    typedef struct packed {
        logic                         enable;
        logic [agc_pkg::SCALE_W-1:0]  scale_delta;
        logic [agc_pkg::OFFSET_W-1:0] offset_delta;
    } servo_cfg_t;

    typedef struct packed {
        logic           load;
        logic           sel_offset;   // 0 loads the scale, 1 the offset
        agc_pkg::gain_t gain;
    } gain_load_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Register reset values
    localparam servo_cfg_t CFG_RESET = '{enable: 1'b1, scale_delta: 17'd30, offset_delta: 16'd25};

endpackage

// ==== rtl/agc_pkg.sv ====
package agc_pkg;

    // Lane geometry
    localparam int N_LANES = 4;
    localparam int IN_W    = 12;
    localparam int OUT_W   = 5;
    localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;    // 15
    localparam int OUT_MIN = -(2 ** (OUT_W - 1));     // -16

    // Gain word formats
    localparam int SCALE_W     = 17;                  // Unsigned
    localparam int SCALE_FRAC  = 10;
    localparam int SCALE_SHIFT = SCALE_FRAC + 7;      // Fraction plus range reduction
    localparam int OFFSET_W    = 16;                  // Signed, 1/16 output step
    localparam int OFFSET_FRAC = 4;

    // Servo limits and start point
    localparam int SCALE_MIN    = 300;
    localparam int SCALE_MAX    = 16384;
    localparam int START_SCALE  = 1500;
    localparam int START_OFFSET = 0;

    // Measurement widths
    localparam int RMS_SQ_W = 9;                      // Holds (-16)^2
    localparam int CNT_W    = 16;

    typedef logic signed [IN_W-1:0]  in_sample_t;
    typedef logic signed [OUT_W-1:0] out_sample_t;

    typedef struct packed {
        logic                      valid;
        in_sample_t [N_LANES-1:0]  lane;
    } in_lanes_t;

    typedef struct packed {
        logic                      valid;
        out_sample_t [N_LANES-1:0] lane;
    } out_lanes_t;

    typedef struct packed {
        logic [SCALE_W-1:0]         scale;
        logic signed [OFFSET_W-1:0] offset;
    } gain_t;

    typedef struct packed {
        logic                done;
        logic [RMS_SQ_W-1:0] rms_sq;
    } power_meas_t;

    typedef struct packed {
        logic             done;
        logic [CNT_W-1:0] pos_cnt;
        logic [CNT_W-1:0] neg_cnt;
    } balance_meas_t;

endpackage
